// File: build.f
hw/fu_pkg.sv
hw/fu_result_if.sv
hw/alu_exec.sv
hw/result_queue.sv
hw/rob_writeback.sv
hw/func_units.sv
verification/func_units_asserts.sv
verification/func_units_checker.sv
verification/func_units_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module func_units_tb

sim:
	verilator --binary --timing --assert -f build.f --top-module func_units_tb -o func_units_sim
	./obj_dir/func_units_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verification/func_units_tb.sv
`default_nettype none

module func_units_tb import fu_pkg::*; ();

  localparam int ROWS           = 15;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * ROWS * 12 + 50;

  logic                    clk;
  logic                    rst;
  logic                    start;
  alu_op_t                 op;
  logic [GPR_SIZE-1:0]     val_a;
  logic [GPR_SIZE-1:0]     val_b;
  logic [ROB_IDX_SIZE-1:0] rob_index;
  logic                    set_nzcv;
  nzcv_t                   nzcv_in;
  cond_t                   cond;
  logic                    alu_ready;
  logic                    rob_stall;
  logic                    done;
  logic [ROB_IDX_SIZE-1:0] out_rob_index;
  logic [GPR_SIZE-1:0]     out_value;
  logic                    out_set_nzcv;
  nzcv_t                   out_nzcv;
  logic                    out_condition;

  logic                    exp_push;
  fu_result_t              exp_entry;
  int                      pending;
  int                      pass_count;
  int                      error_count;
  int                      tb_errors;
  int                      latency;
  int                      next_row;
  int                      row_count;
  int                      cycles;
  int                      seed;
  logic [31:0]             rand_word;
  logic                    stall_en;
  logic                    saw_not_ready;

  // Stimulus table with hand-worked expected results
  alu_op_t                 tbl_op [ROWS];
  logic [GPR_SIZE-1:0]     tbl_a [ROWS];
  logic [GPR_SIZE-1:0]     tbl_b [ROWS];
  logic                    tbl_set [ROWS];
  nzcv_t                   tbl_nzcv [ROWS];
  cond_t                   tbl_cond [ROWS];
  logic [GPR_SIZE-1:0]     tbl_value [ROWS];
  nzcv_t                   tbl_flags [ROWS];
  logic                    tbl_holds [ROWS];

  func_units i_dut (.*);

  func_units_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .done          (done),
    .out_rob_index (out_rob_index),
    .out_value     (out_value),
    .out_set_nzcv  (out_set_nzcv),
    .out_nzcv      (out_nzcv),
    .out_condition (out_condition),
    .exp_push      (exp_push),
    .exp_entry     (exp_entry),
    .pending       (pending),
    .pass_count    (pass_count),
    .error_count   (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d results outstanding", cycles, pending);
    $display("Test failed");
    $finish;
  end

  // Random ROB back-pressure for the second pass
  initial begin
    seed          = 55390;
    rob_stall     = 1'b0;
    saw_not_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (stall_en) begin
        rand_word = $random(seed);
        rob_stall = rand_word[0];
        if (!alu_ready) saw_not_ready = 1'b1;
      end else begin
        rob_stall = 1'b0;
      end
    end
  end

  task automatic add_row(input alu_op_t row_op, input logic [GPR_SIZE-1:0] a,
                         input logic [GPR_SIZE-1:0] b, input logic set,
                         input nzcv_t flags_in, input cond_t c,
                         input logic [GPR_SIZE-1:0] value, input nzcv_t flags,
                         input logic holds);
    tbl_op[row_count]    = row_op;
    tbl_a[row_count]     = a;
    tbl_b[row_count]     = b;
    tbl_set[row_count]   = set;
    tbl_nzcv[row_count]  = flags_in;
    tbl_cond[row_count]  = c;
    tbl_value[row_count] = value;
    tbl_flags[row_count] = flags;
    tbl_holds[row_count] = holds;
    row_count++;
  endtask

  task automatic drive_row(input int i);
    start     = 1'b1;
    op        = tbl_op[i];
    val_a     = tbl_a[i];
    val_b     = tbl_b[i];
    rob_index = ROB_IDX_SIZE'(i);
    set_nzcv  = tbl_set[i];
    nzcv_in   = tbl_nzcv[i];
    cond      = tbl_cond[i];
    exp_entry = '{rob_index: ROB_IDX_SIZE'(i), value: tbl_value[i], set_nzcv: tbl_set[i],
                  nzcv: tbl_flags[i], condition: tbl_holds[i]};
    exp_push  = 1'b1;
  endtask

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    op        = ALU_OP_PLUS;
    val_a     = '0;
    val_b     = '0;
    rob_index = '0;
    set_nzcv  = 1'b0;
    nzcv_in   = '0;
    cond      = AL;
    exp_push  = 1'b0;
    exp_entry = '0;
    stall_en  = 1'b0;
    tb_errors = 0;
    row_count = 0;

    // Carry and overflow corners
    add_row(ALU_OP_PLUS, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 1'b1, 4'b0000, AL,
            64'h0, 4'b0110, 1'b1);
    add_row(ALU_OP_MINUS, 64'h8000_0000_0000_0000, 64'h1, 1'b1, 4'b0000, AL,
            64'h7FFF_FFFF_FFFF_FFFF, 4'b0011, 1'b1);
    add_row(ALU_OP_PLUS, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1, 1'b1, 4'b0000, AL,
            64'h8000_0000_0000_0000, 4'b1001, 1'b1);
    add_row(ALU_OP_MINUS, 64'h5, 64'h7, 1'b1, 4'b0000, AL,
            64'hFFFF_FFFF_FFFF_FFFE, 4'b1000, 1'b1);
    // Flags pass through when set_nzcv is clear
    add_row(ALU_OP_MINUS, 64'h1234, 64'h1234, 1'b0, 4'b1010, AL,
            64'h0, 4'b1010, 1'b1);
    add_row(ALU_OP_ORN, 64'hF0, 64'hFFFF_FFFF_0000_FFFF, 1'b1, 4'b1111, AL,
            64'h0000_0000_FFFF_00F0, 4'b0000, 1'b1);
    add_row(ALU_OP_OR, 64'h8000_0000_0000_0000, 64'h1, 1'b1, 4'b0110, EQ,
            64'h8000_0000_0000_0001, 4'b1000, 1'b1);
    add_row(ALU_OP_EOR, 64'hDEAD_BEEF_DEAD_BEEF, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, 4'b0000, AL,
            64'h0, 4'b0100, 1'b1);
    add_row(ALU_OP_AND, 64'hFF00_FF00_FF00_FF00, 64'h0F0F_0F0F_0F0F_0F0F, 1'b0, 4'b0001, AL,
            64'h0F00_0F00_0F00_0F00, 4'b0001, 1'b1);
    // Conditional selects that hold and fail
    add_row(ALU_OP_CSEL, 64'h1111, 64'h2222, 1'b0, 4'b0100, EQ,
            64'h1111, 4'b0100, 1'b1);
    add_row(ALU_OP_CSINC, 64'h5, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 4'b0100, NE,
            64'h0, 4'b0100, 1'b0);
    add_row(ALU_OP_CSINV, 64'h7, 64'hFF, 1'b1, 4'b1000, GE,
            64'hFFFF_FFFF_FFFF_FF00, 4'b1000, 1'b0);
    add_row(ALU_OP_CSNEG, 64'hABCD, 64'h1, 1'b0, 4'b1000, LT,
            64'hABCD, 4'b1000, 1'b1);
    add_row(ALU_OP_CSNEG, 64'h9, 64'h5, 1'b1, 4'b0110, HI,
            64'hFFFF_FFFF_FFFF_FFFB, 4'b1000, 1'b0);
    add_row(ALU_OP_CSINC, 64'h8000_0000_0000_0000, 64'h1, 1'b1, 4'b0011, AL,
            64'h8000_0000_0000_0000, 4'b1000, 1'b1);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // First pass with one issue at a time and fixed latency
    for (int i = 0; i < ROWS; i++) begin
      @(negedge clk);
      while (!alu_ready) @(negedge clk);
      drive_row(i);
      @(negedge clk);
      start    = 1'b0;
      exp_push = 1'b0;
      latency  = 0;
      while (!done) begin
        @(negedge clk);
        latency++;
      end
      if (latency != 2) begin
        $display("Row %0d delivered %0d cycles after issue instead of 2", i, latency);
        tb_errors++;
      end
    end

    // Second pass with back-to-back issue under random stall
    @(posedge clk);
    stall_en = 1'b1;
    next_row = 0;
    while (next_row < ROWS) begin
      @(negedge clk);
      start    = 1'b0;
      exp_push = 1'b0;
      if (alu_ready) begin
        drive_row(next_row);
        next_row++;
      end
    end
    @(negedge clk);
    start    = 1'b0;
    exp_push = 1'b0;
    while (pending != 0) @(negedge clk);
    @(posedge clk);
    stall_en = 1'b0;
    repeat (5) @(negedge clk);

    if (!saw_not_ready) begin
      $display("alu_ready never fell while the ROB was stalling");
      tb_errors++;
    end
    if (pass_count + error_count != 2 * ROWS) begin
      $display("%0d results were checked but %0d were issued", pass_count + error_count,
               2 * ROWS);
      tb_errors++;
    end
    $display("Results passed: %0d, errors: %0d", pass_count, error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/func_units_checker.sv
`default_nettype none

module func_units_checker import fu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    done,
  input  logic [ROB_IDX_SIZE-1:0] out_rob_index,
  input  logic [GPR_SIZE-1:0]     out_value,
  input  logic                    out_set_nzcv,
  input  nzcv_t                   out_nzcv,
  input  logic                    out_condition,
  input  logic                    exp_push,
  input  fu_result_t              exp_entry,
  output int                      pending,
  output int                      pass_count,
  output int                      error_count
);

  // Expected results in issue order
  fu_result_t expected_q [$];
  fu_result_t exp_head;
  int         passed = 0;
  int         failed = 0;
  int         queued = 0;
  logic       ok;

  task automatic check_field(input string name, input logic [GPR_SIZE-1:0] expected,
                             input logic [GPR_SIZE-1:0] actual, inout logic match);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      match = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (exp_push) begin
      expected_q.push_back(exp_entry);
    end
    if (!rst && done) begin
      if (expected_q.size() == 0) begin
        $display("Extra result delivered with rob_index 0x%0h", out_rob_index);
        failed++;
      end else begin
        exp_head = expected_q.pop_front();
        ok = 1'b1;
        check_field("out_rob_index", GPR_SIZE'(exp_head.rob_index),
                    GPR_SIZE'(out_rob_index), ok);
        check_field("out_value", exp_head.value, out_value, ok);
        check_field("out_set_nzcv", GPR_SIZE'(exp_head.set_nzcv), GPR_SIZE'(out_set_nzcv), ok);
        check_field("out_nzcv", GPR_SIZE'(exp_head.nzcv), GPR_SIZE'(out_nzcv), ok);
        check_field("out_condition", GPR_SIZE'(exp_head.condition),
                    GPR_SIZE'(out_condition), ok);
        if (ok) passed++;
        else failed++;
        $display("Result rob_index 0x%0h value 0x%0h nzcv 0x%0h: %s", out_rob_index,
                 out_value, out_nzcv, ok ? "ok" : "mismatch");
      end
    end
    queued = expected_q.size();
  end

  assign pending     = queued;
  assign pass_count  = passed;
  assign error_count = failed;

endmodule

`default_nettype wire

// File: verification/func_units_asserts.sv
`default_nettype none

module func_units_asserts (
  input logic clk,
  input logic rst,
  input logic start,
  input logic alu_ready,
  input logic rob_stall,
  input logic done
);

  // Reservation station may only issue into free space
  assert property (@(posedge clk) disable iff (rst) start |-> alu_ready)
    else $error("start raised while alu_ready is low");

  // A stalled ROB gets no delivery in the following cycle
  assert property (@(posedge clk) disable iff (rst) rob_stall |=> !done)
    else $error("done pulsed after a cycle with rob_stall high");

  assert property (@(posedge clk) rst |=> !done)
    else $error("done is high right after reset");

endmodule

bind func_units func_units_asserts i_asserts (
  .clk       (clk),
  .rst       (rst),
  .start     (start),
  .alu_ready (alu_ready),
  .rob_stall (rob_stall),
  .done      (done)
);

`default_nettype wire

// File: hw/func_units.sv
`default_nettype none

module func_units import fu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  // Issue from the reservation station
  input  logic                    start,
  input  alu_op_t                 op,
  input  logic [GPR_SIZE-1:0]     val_a,
  input  logic [GPR_SIZE-1:0]     val_b,
  input  logic [ROB_IDX_SIZE-1:0] rob_index,
  input  logic                    set_nzcv,
  input  nzcv_t                   nzcv_in,
  input  cond_t                   cond,
  output logic                    alu_ready,
  // Writeback to the ROB
  input  logic                    rob_stall,
  output logic                    done,
  output logic [ROB_IDX_SIZE-1:0] out_rob_index,
  output logic [GPR_SIZE-1:0]     out_value,
  output logic                    out_set_nzcv,
  output nzcv_t                   out_nzcv,
  output logic                    out_condition
);

  fu_result_if res_in ();
  fu_result_if res_out ();

  alu_exec i_alu_exec (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .op        (op),
    .val_a     (val_a),
    .val_b     (val_b),
    .rob_index (rob_index),
    .set_nzcv  (set_nzcv),
    .nzcv_in   (nzcv_in),
    .cond      (cond),
    .alu_ready (alu_ready),
    .res       (res_in.source)
  );

  result_queue i_result_queue (
    .clk (clk),
    .rst (rst),
    .wr  (res_in.sink),
    .rd  (res_out.source)
  );

  rob_writeback i_rob_writeback (
    .clk           (clk),
    .rst           (rst),
    .rob_stall     (rob_stall),
    .q             (res_out.sink),
    .done          (done),
    .out_rob_index (out_rob_index),
    .out_value     (out_value),
    .out_set_nzcv  (out_set_nzcv),
    .out_nzcv      (out_nzcv),
    .out_condition (out_condition)
  );

endmodule

`default_nettype wire

// File: hw/rob_writeback.sv
`default_nettype none

module rob_writeback import fu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rob_stall,
  fu_result_if.sink               q,
  output logic                    done,
  output logic [ROB_IDX_SIZE-1:0] out_rob_index,
  output logic [GPR_SIZE-1:0]     out_value,
  output logic                    out_set_nzcv,
  output nzcv_t                   out_nzcv,
  output logic                    out_condition
);

  logic       load;
  fu_result_t out_q;

  // Pop the head whenever the ROB can accept it
  assign load   = q.valid && !rob_stall;
  assign q.take = load;

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= load;
    end
  end

  // Fields hold between deliveries
  always_ff @(posedge clk) begin
    if (load) begin
      out_q <= '{
        rob_index: q.rob_index,
        value:     q.value,
        set_nzcv:  q.set_nzcv,
        nzcv:      q.nzcv,
        condition: q.condition
      };
    end
  end

  assign out_rob_index = out_q.rob_index;
  assign out_value     = out_q.value;
  assign out_set_nzcv  = out_q.set_nzcv;
  assign out_nzcv      = out_q.nzcv;
  assign out_condition = out_q.condition;

endmodule

`default_nettype wire

// File: hw/result_queue.sv
`default_nettype none

module result_queue import fu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  fu_result_if.sink   wr,
  fu_result_if.source rd
);

  fu_result_t                mem [RESULT_QUEUE_DEPTH];
  fu_result_t                wr_entry;
  fu_result_t                head;
  logic [QUEUE_PTR_SIZE-1:0] wr_ptr;
  logic [QUEUE_PTR_SIZE-1:0] rd_ptr;
  logic [QUEUE_CNT_SIZE-1:0] count;
  logic                      push;
  logic                      pop;

  function automatic logic [QUEUE_PTR_SIZE-1:0] next_ptr(
    input logic [QUEUE_PTR_SIZE-1:0] ptr
  );
    return (ptr == QUEUE_LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign push = wr.valid && (count != QUEUE_FULL_COUNT);
  assign pop  = rd.take && (count != '0);

  assign wr_entry = '{
    rob_index: wr.rob_index,
    value:     wr.value,
    set_nzcv:  wr.set_nzcv,
    nzcv:      wr.nzcv,
    condition: wr.condition
  };

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Room for at least two more results
  assign wr.take = (count <= QUEUE_TAKE_MAX);

  assign head         = mem[rd_ptr];
  assign rd.valid     = (count != '0);
  assign rd.rob_index = head.rob_index;
  assign rd.value     = head.value;
  assign rd.set_nzcv  = head.set_nzcv;
  assign rd.nzcv      = head.nzcv;
  assign rd.condition = head.condition;

endmodule

`default_nettype wire

// File: hw/alu_exec.sv
`default_nettype none

module alu_exec import fu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  alu_op_t                 op,
  input  logic [GPR_SIZE-1:0]     val_a,
  input  logic [GPR_SIZE-1:0]     val_b,
  input  logic [ROB_IDX_SIZE-1:0] rob_index,
  input  logic                    set_nzcv,
  input  nzcv_t                   nzcv_in,
  input  cond_t                   cond,
  output logic                    alu_ready,
  fu_result_if.source             res
);

  // Issue register
  logic                    busy;
  alu_op_t                 op_q;
  logic [GPR_SIZE-1:0]     a_q;
  logic [GPR_SIZE-1:0]     b_q;
  logic [ROB_IDX_SIZE-1:0] rob_index_q;
  logic                    set_nzcv_q;
  nzcv_t                   nzcv_q;
  cond_t                   cond_q;

  logic                    cond_holds;
  logic [GPR_SIZE:0]       result;
  logic                    a_neg;
  logic                    b_neg;
  logic                    res_neg;
  nzcv_t                   flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else begin
      busy <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q        <= op;
      a_q         <= val_a;
      b_q         <= val_b;
      rob_index_q <= rob_index;
      set_nzcv_q  <= set_nzcv;
      nzcv_q      <= nzcv_in;
      cond_q      <= cond;
    end
  end

  always_comb begin
    case (cond_q)
      EQ:      cond_holds = nzcv_q.Z;
      NE:      cond_holds = !nzcv_q.Z;
      CS:      cond_holds = nzcv_q.C;
      CC:      cond_holds = !nzcv_q.C;
      MI:      cond_holds = nzcv_q.N;
      PL:      cond_holds = !nzcv_q.N;
      VS:      cond_holds = nzcv_q.V;
      VC:      cond_holds = !nzcv_q.V;
      HI:      cond_holds = nzcv_q.C && !nzcv_q.Z;
      LS:      cond_holds = !(nzcv_q.C && !nzcv_q.Z);
      GE:      cond_holds = (nzcv_q.N == nzcv_q.V);
      LT:      cond_holds = (nzcv_q.N != nzcv_q.V);
      GT:      cond_holds = !nzcv_q.Z && (nzcv_q.N == nzcv_q.V);
      LE:      cond_holds = nzcv_q.Z || (nzcv_q.N != nzcv_q.V);
      default: cond_holds = 1'b1;  // AL and NV
    endcase
  end

  // Bit GPR_SIZE carries the adder carry out
  always_comb begin
    case (op_q)
      ALU_OP_PLUS:  result = {1'b0, a_q} + {1'b0, b_q};
      ALU_OP_MINUS: result = {1'b0, a_q} + {1'b0, ~b_q} + 1'b1;
      ALU_OP_ORN:   result = {1'b0, a_q | ~b_q};
      ALU_OP_OR:    result = {1'b0, a_q | b_q};
      ALU_OP_EOR:   result = {1'b0, a_q ^ b_q};
      ALU_OP_AND:   result = {1'b0, a_q & b_q};
      ALU_OP_CSEL:  result = cond_holds ? {1'b0, a_q} : {1'b0, b_q};
      ALU_OP_CSINC: result = cond_holds ? {1'b0, a_q} : {1'b0, b_q + 1'b1};
      ALU_OP_CSINV: result = cond_holds ? {1'b0, a_q} : {1'b0, ~b_q};
      ALU_OP_CSNEG: result = cond_holds ? {1'b0, a_q} : {1'b0, ~b_q + 1'b1};
      default:      result = '0;
    endcase
  end

  assign a_neg   = a_q[GPR_SIZE-1];
  assign b_neg   = b_q[GPR_SIZE-1];
  assign res_neg = result[GPR_SIZE-1];

  always_comb begin
    flags = nzcv_q;
    if (set_nzcv_q) begin
      flags.N = res_neg;
      flags.Z = (result[GPR_SIZE-1:0] == '0);
      flags.C = 1'b0;
      flags.V = 1'b0;
      if (op_q == ALU_OP_PLUS) begin
        flags.C = result[GPR_SIZE];
        flags.V = (a_neg == b_neg) && (res_neg != a_neg);
      end else if (op_q == ALU_OP_MINUS) begin
        // Carry set means no borrow
        flags.C = result[GPR_SIZE];
        flags.V = (a_neg != b_neg) && (res_neg != a_neg);
      end
    end
  end

  assign res.valid     = busy;
  assign res.rob_index = rob_index_q;
  assign res.value     = result[GPR_SIZE-1:0];
  assign res.set_nzcv  = set_nzcv_q;
  assign res.nzcv      = flags;
  assign res.condition = cond_holds;

  assign alu_ready = res.take;

endmodule

`default_nettype wire

// File: hw/fu_result_if.sv
`default_nettype none

interface fu_result_if import fu_pkg::*; ();

  logic                    valid;
  logic                    take;
  logic [ROB_IDX_SIZE-1:0] rob_index;
  logic [GPR_SIZE-1:0]     value;
  logic                    set_nzcv;
  nzcv_t                   nzcv;
  logic                    condition;

  // Producer side of a result link
  modport source (
    output valid, rob_index, value, set_nzcv, nzcv, condition,
    input  take
  );

  modport sink (
    input  valid, rob_index, value, set_nzcv, nzcv, condition,
    output take
  );

endinterface

`default_nettype wire

// File: hw/fu_pkg.sv
`default_nettype none

package fu_pkg;

  // Datapath widths
  localparam int GPR_SIZE     = 64;
  localparam int ROB_IDX_SIZE = 4;

  // Result queue geometry
  localparam int RESULT_QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_SIZE     = $clog2(RESULT_QUEUE_DEPTH);
  localparam int QUEUE_CNT_SIZE     = $clog2(RESULT_QUEUE_DEPTH + 1);

  localparam logic [QUEUE_PTR_SIZE-1:0] QUEUE_LAST_PTR   = QUEUE_PTR_SIZE'(RESULT_QUEUE_DEPTH - 1);
  localparam logic [QUEUE_CNT_SIZE-1:0] QUEUE_FULL_COUNT = QUEUE_CNT_SIZE'(RESULT_QUEUE_DEPTH);
  // Two free slots cover the issue register plus one new issue
  localparam logic [QUEUE_CNT_SIZE-1:0] QUEUE_TAKE_MAX   = QUEUE_CNT_SIZE'(RESULT_QUEUE_DEPTH - 2);

  typedef enum logic [3:0] {
    ALU_OP_PLUS  = 4'd0,
    ALU_OP_MINUS = 4'd1,
    ALU_OP_ORN   = 4'd2,
    ALU_OP_OR    = 4'd3,
    ALU_OP_EOR   = 4'd4,
    ALU_OP_AND   = 4'd5,
    ALU_OP_CSEL  = 4'd6,
    ALU_OP_CSINC = 4'd7,
    ALU_OP_CSINV = 4'd8,
    ALU_OP_CSNEG = 4'd9
  } alu_op_t;

  // ARM condition codes in architectural encoding order
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } cond_t;

  typedef struct packed {
    logic N;
    logic Z;
    logic C;
    logic V;
  } nzcv_t;

  // One finished result, 74 bits
  typedef struct packed {
    logic [ROB_IDX_SIZE-1:0] rob_index;
    logic [GPR_SIZE-1:0]     value;
    logic                    set_nzcv;
    nzcv_t                   nzcv;
    logic                    condition;
  } fu_result_t;

endpackage

`default_nettype wire
